// ==== all.f ====
verilog/layer_pkg.sv
verilog/axi_read_pkg.sv
verilog/stream_control.sv
verilog/row_fetch.sv
verilog/row_ring_buffer.sv
verilog/window_shifter.sv
verilog/int_to_half.sv
verilog/window_fifo.sv
verilog/window_stream_top.sv
verification/window_stream_asserts.sv
verification/window_stream_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= window_stream_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/window_stream_tb.sv ====
module window_stream_tb;

	typedef struct packed {
		layer_pkg::layer_cfg_t cfg;
		logic [1:0]            ready_code;
		logic [15:0]           exp_windows;
	} case_t;

	logic                  clk;
	logic                  reset_n;
	logic                  start;
	layer_pkg::layer_cfg_t cfg;
	axi_read_pkg::axi_ar_t ar;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_read_pkg::axi_r_t  r;
	logic                  r_valid;
	logic                  r_ready;
	layer_pkg::window_t    out_window;
	logic                  out_valid;
	logic                  out_ready;
	logic                  done;

	case_t                 tbl [4];
	int                    cur;
	int                    rows_seen;
	int                    win_idx;
	int                    done_cnt;
	int                    beat_idx;
	int                    cycles;
	int                    limit;
	logic [31:0]           lfsr;
	logic                  rdy;
	axi_read_pkg::axi_ar_t burst_q [$];

	window_stream_top #(.MAX_COLS(32), .FIFO_DEPTH(16)) DUT (.*);

	always #20 clk = ~clk;

	// --------------------------------------------------
	// random bits and memory contents
	// --------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	// ready drops with chance 2^-code and never for code 0
	task automatic draw_ready(input logic [1:0] code, output logic ready);
		logic b;
		ready = (code == 2'd0);
		for (int i = 0; i < int'(code); i++) begin
			take_bit(b);
			if (!b) ready = 1'b1;
		end
	endtask

	function automatic logic [15:0] pixel_at(input logic [31:0] a);
		return a[16:1] ^ 16'h5a5a;
	endfunction

	function automatic logic [127:0] beat_data(input logic [31:0] addr, input int b);
		logic [127:0] d;
		for (int j = 0; j < 8; j++) d[16*j +: 16] = pixel_at(addr + 32'(16 * b + 2 * j));
		return d;
	endfunction

	// --------------------------------------------------
	// golden values
	// --------------------------------------------------
	function automatic logic [15:0] half_of(input logic [15:0] v);
		int         mag;
		int         msb;
		logic [9:0] man;
		mag = v[15] ? 65536 - int'(v) : int'(v);
		if (mag == 0) return 16'h0000;
		msb = $clog2(mag + 1) - 1;
		man = (msb >= 10) ? 10'(mag >> (msb - 10)) : 10'(mag << (10 - msb));
		return {v[15], 5'(15 + msb), man};
	endfunction

	function automatic layer_pkg::window_t expected_window(input int e, input int idx);
		layer_pkg::window_t w;
		int                 rr;
		int                 c;
		int                 row;
		logic [15:0]        v;
		rr = idx / (int'(tbl[e].cfg.cols) - 2);
		c = idx % (int'(tbl[e].cfg.cols) - 2);
		for (int k = 0; k < 3; k++) begin
			for (int j = 0; j < 3; j++) begin
				row = rr - 1 + k;
				// zero rows above the first and below the last
				if (row < 0 || row >= int'(tbl[e].cfg.rows)) v = '0;
				else v = pixel_at(tbl[e].cfg.base_addr
					+ 32'(row) * 32'(tbl[e].cfg.row_stride) + 32'(2 * (c + j)));
				w[3 * k + j] = tbl[e].cfg.cast ? half_of(v) : v;
			end
		end
		return w;
	endfunction

	function automatic axi_read_pkg::axi_ar_t expected_ar(input int e, input int row);
		return '{addr: tbl[e].cfg.base_addr + 32'(row) * 32'(tbl[e].cfg.row_stride),
			len: 8'((int'(tbl[e].cfg.cols) - 1) / 8), size: 3'd4, burst: 2'd1};
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic stop_with_failure();
		$display("Finished with errors");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_window(input string name, input layer_pkg::window_t got,
		input layer_pkg::window_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_ar(input string name, input axi_read_pkg::axi_ar_t got,
		input axi_read_pkg::axi_ar_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// --------------------------------------------------
	// memory model, output sink and monitors
	// --------------------------------------------------
	always @(posedge clk) begin
		if (start) begin
			rows_seen = 0;
			win_idx = 0;
			done_cnt = 0;
		end
		if (done) done_cnt++;
		if (ar_valid && ar_ready) begin
			check_ar($sformatf("ar row %0d", rows_seen), ar, expected_ar(cur, rows_seen));
			burst_q.push_back(ar);
			rows_seen++;
		end
		if (r_valid && r_ready) begin
			if (beat_idx == int'(burst_q[0].len)) begin
				void'(burst_q.pop_front());
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
		// a beat that was not taken stays on the bus
		if (!(r_valid && !r_ready)) begin
			if (burst_q.size() > 0) begin
				draw_ready(tbl[cur].ready_code, rdy);
				r_valid <= rdy;
				r <= '{data: beat_data(burst_q[0].addr, beat_idx), resp: 2'b00,
					last: (beat_idx == int'(burst_q[0].len))};
			end else begin
				r_valid <= 1'b0;
			end
		end
		if (out_valid && out_ready) begin
			check_window($sformatf("out_window %0d", win_idx), out_window,
				expected_window(cur, win_idx));
			win_idx++;
		end
		draw_ready(tbl[cur].ready_code, rdy);
		ar_ready <= rdy;
		draw_ready(tbl[cur].ready_code, rdy);
		out_ready <= rdy;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			stop_with_failure();
		end
	end

	// --------------------------------------------------
	// stimulus table with one start per entry
	// --------------------------------------------------
	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		ar_ready = 1'b0;
		r = '0;
		r_valid = 1'b0;
		out_ready = 1'b0;
		lfsr = 32'hddf;
		cur = 0;
		rows_seen = 0;
		win_idx = 0;
		done_cnt = 0;
		beat_idx = 0;
		cycles = 0;
		// single row
		tbl[0] = '{cfg: '{base_addr: 32'h0000_1000, row_stride: 16'd16, rows: 8'd1,
			cols: 6'd5, cast: 1'b0}, ready_code: 2'd0, exp_windows: 16'd3};
		// two beats per row
		tbl[1] = '{cfg: '{base_addr: 32'h0000_2000, row_stride: 16'd32, rows: 8'd4,
			cols: 6'd12, cast: 1'b0}, ready_code: 2'd1, exp_windows: 16'd40};
		// negative pixels including -32768
		tbl[2] = '{cfg: '{base_addr: 32'h0001_b4b0, row_stride: 16'd48, rows: 8'd5,
			cols: 6'd10, cast: 1'b1}, ready_code: 2'd2, exp_windows: 16'd40};
		tbl[3] = '{cfg: '{base_addr: 32'h0000_4000, row_stride: 16'd64, rows: 8'd6,
			cols: 6'd32, cast: 1'b0}, ready_code: 2'd1, exp_windows: 16'd180};
		limit = 2000;
		for (int i = 0; i < 4; i++) begin
			limit += 80 * int'(tbl[i].cfg.rows) * int'(tbl[i].cfg.cols);
		end
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		for (int e = 0; e < 4; e++) begin
			@(posedge clk);
			cur <= e;
			cfg <= tbl[e].cfg;
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			while (!done) @(posedge clk);
			while (win_idx < int'(tbl[e].exp_windows)) @(posedge clk);
			// late extra windows or pulses would show up here
			repeat (20) @(posedge clk);
			@(negedge clk);
			check_count("done pulses", done_cnt, 1);
			check_count("windows", win_idx, int'(tbl[e].exp_windows));
			check_count("rows requested", rows_seen, int'(tbl[e].cfg.rows));
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== verification/window_stream_asserts.sv ====
module window_stream_asserts (
	input logic                  clk,
	input logic                  reset_n,
	input axi_read_pkg::axi_ar_t ar,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input logic                  r_ready,
	input layer_pkg::window_t    out_window,
	input logic                  out_valid,
	input logic                  out_ready,
	input logic                  done
);

	// --------------------------------------------------
	// handshake stability
	// --------------------------------------------------
	ar_held: assert property (@(posedge clk) disable iff (!reset_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else $error("ar changed or dropped before ar_ready");

	out_held: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid && $stable(out_window))
		else $error("out_window changed or dropped before out_ready");

	done_single: assert property (@(posedge clk) disable iff (!reset_n)
		done |=> !done)
		else $error("done lasted more than one cycle");

	// from the second reset edge on, the first one clears the state
	reset_quiet: assert property (@(posedge clk)
		!reset_n && $past(!reset_n) |-> !ar_valid && !r_ready && !out_valid && !done)
		else $error("outputs active during reset");

endmodule

bind window_stream_top window_stream_asserts u_asserts (.*);

// ==== verilog/window_stream_top.sv ====
module window_stream_top #(
	parameter int MAX_COLS = 32,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  layer_pkg::layer_cfg_t  cfg,
	output axi_read_pkg::axi_ar_t  ar,
	output logic                   ar_valid,
	input  logic                   ar_ready,
	input  axi_read_pkg::axi_r_t   r,
	input  logic                   r_valid,
	output logic                   r_ready,
	output layer_pkg::window_t     out_window,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   done
);
	localparam int BEAT_W = layer_pkg::beat_bits(MAX_COLS);

	logic                                 fetch_req;
	logic                                 fetch_ack;
	layer_pkg::fetch_req_t                fetch_row;
	logic                                 job_req;
	logic                                 job_ack;
	layer_pkg::row_job_t                  job;
	logic                                 wr_en;
	logic [1:0]                           wr_slot;
	logic [BEAT_W-1:0]                    wr_beat;
	logic [axi_read_pkg::DATA_W-1:0]      wr_data;
	logic [2:0][1:0]                      rd_slot;
	logic [BEAT_W-1:0]                    rd_beat;
	logic [2:0][axi_read_pkg::DATA_W-1:0] rd_data;
	logic                                 has_space;
	layer_pkg::window_t                   sh_win;
	logic                                 sh_valid;
	layer_pkg::window_t                   cast_win;
	logic                                 cast_valid;

	stream_control u_control (
		.clk(clk), .reset_n(reset_n), .start(start), .rows(cfg.rows),
		.fetch_req(fetch_req), .fetch_row(fetch_row), .fetch_ack(fetch_ack),
		.job_req(job_req), .job(job), .job_ack(job_ack), .done(done)
	);

	row_fetch #(.MAX_COLS(MAX_COLS)) u_fetch (
		.clk(clk), .reset_n(reset_n), .cfg(cfg),
		.fetch_req(fetch_req), .fetch_row(fetch_row), .fetch_ack(fetch_ack),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.wr_en(wr_en), .wr_slot(wr_slot), .wr_beat(wr_beat), .wr_data(wr_data)
	);

	row_ring_buffer #(.MAX_COLS(MAX_COLS)) u_ring (
		.clk(clk), .wr_en(wr_en), .wr_slot(wr_slot), .wr_beat(wr_beat), .wr_data(wr_data),
		.rd_slot(rd_slot), .rd_beat(rd_beat), .rd_data(rd_data)
	);

	window_shifter #(.MAX_COLS(MAX_COLS)) u_shifter (
		.clk(clk), .reset_n(reset_n), .cols(cfg.cols),
		.job_req(job_req), .job(job), .job_ack(job_ack),
		.rd_slot(rd_slot), .rd_beat(rd_beat), .rd_data(rd_data),
		.has_space(has_space), .win(sh_win), .win_valid(sh_valid)
	);

	int_to_half u_cast (
		.clk(clk), .reset_n(reset_n), .cast(cfg.cast),
		.win(sh_win), .win_valid(sh_valid), .out_win(cast_win), .out_valid(cast_valid)
	);

	window_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .reset_n(reset_n), .in_win(cast_win), .in_valid(cast_valid),
		.out_window(out_window), .out_valid(out_valid), .out_ready(out_ready),
		.has_space(has_space)
	);

endmodule

// ==== verilog/window_fifo.sv ====
module window_fifo #(
	parameter int FIFO_DEPTH = 16,
	localparam int PTR_W = $clog2(FIFO_DEPTH),
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1)
) (
	input  logic               clk,
	input  logic               reset_n,
	input  layer_pkg::window_t in_win,
	input  logic               in_valid,
	output layer_pkg::window_t out_window,
	output logic               out_valid,
	input  logic               out_ready,
	output logic               has_space
);
	layer_pkg::window_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               pop;

	assign out_valid = (count != '0);
	assign out_window = mem[rd_ptr];
	assign pop = out_valid && out_ready;

	// room for the cast register and the window in flight
	assign has_space = (count <= CNT_W'(FIFO_DEPTH - 3));

	always_ff @(posedge clk) begin
		if (in_valid) mem[wr_ptr] <= in_win;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (in_valid) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
		end
	end

endmodule

// ==== verilog/int_to_half.sv ====
module int_to_half (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               cast,
	input  layer_pkg::window_t win,
	input  logic               win_valid,
	output layer_pkg::window_t out_win,
	output logic               out_valid
);

	// truncating int16 to fp16, -32768 lands on exponent 30 by itself
	function automatic layer_pkg::pixel_t to_half(input layer_pkg::pixel_t p);
		layer_pkg::pixel_t h;
		logic [15:0]       mag;
		logic [15:0]       norm;
		int                msb;
		h = '0;
		msb = 0;
		mag = p.int_val[15] ? 16'(-p.int_val) : p.int_val;
		for (int i = 0; i < 16; i++) begin
			if (mag[i]) msb = i;
		end
		if (mag != 16'd0) begin
			norm = mag << (15 - msb);
			h.half.sign = p.int_val[15];
			h.half.exponent = 5'(15 + msb);
			h.half.mantissa = norm[14:5];
		end
		return h;
	endfunction

	always_ff @(posedge clk) begin
		for (int i = 0; i < layer_pkg::WINDOW_PIXELS; i++) begin
			out_win[i] <= cast ? to_half(win[i]) : win[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) out_valid <= 1'b0;
		else out_valid <= win_valid;
	end

endmodule

// ==== verilog/window_shifter.sv ====
module window_shifter #(
	parameter int MAX_COLS = 32,
	localparam int BEAT_W = layer_pkg::beat_bits(MAX_COLS)
) (
	input  logic                                 clk,
	input  logic                                 reset_n,
	input  logic [5:0]                           cols,
	input  logic                                 job_req,
	input  layer_pkg::row_job_t                  job,
	output logic                                 job_ack,
	output logic [2:0][1:0]                      rd_slot,
	output logic [BEAT_W-1:0]                    rd_beat,
	input  logic [2:0][axi_read_pkg::DATA_W-1:0] rd_data,
	input  logic                                 has_space,
	output layer_pkg::window_t                   win,
	output logic                                 win_valid
);
	localparam int PPB = layer_pkg::PIXELS_PER_BEAT;
	localparam int LINE_PIX = PPB << BEAT_W;
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_LOAD = 2'd1;
	localparam logic [1:0] S_EMIT = 2'd2;
	localparam logic [1:0] S_ACK = 2'd3;

	layer_pkg::pixel_t [LINE_PIX-1:0] lines [3];
	logic [1:0]        state;
	logic [BEAT_W-1:0] issue_beat;
	logic              issue_done;
	logic              issuing;
	logic              rd_pend;
	logic [BEAT_W-1:0] rd_beat_q;
	logic [5:0]        win_cnt;
	logic [6:0]        beats_sum;
	logic [BEAT_W-1:0] last_beat;

	assign beats_sum = {1'b0, cols} + 7'd7;
	assign last_beat = BEAT_W'((beats_sum >> 3) - 7'd1);
	assign issuing = (state == S_LOAD) && !issue_done;

	// rows above, at and below the centre
	assign rd_slot[0] = job.slot - 2'd1;
	assign rd_slot[1] = job.slot;
	assign rd_slot[2] = job.slot + 2'd1;
	assign rd_beat = issue_beat;
	assign job_ack = (state == S_ACK);
	assign win_valid = (state == S_EMIT) && has_space;

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			for (int c = 0; c < 3; c++) begin
				win[3 * k + c] = lines[k][c];
			end
		end
	end

	// --------------------------------------------------
	// pixel lines, beat writes then one pixel shifts
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		for (int k = 0; k < 3; k++) begin
			if (rd_pend) begin
				if ((k == 0 && job.top_pad) || (k == 2 && job.bottom_pad)) begin
					lines[k][rd_beat_q * PPB +: PPB] <= '0;
				end else begin
					lines[k][rd_beat_q * PPB +: PPB] <= rd_data[k];
				end
			end else if (win_valid) begin
				lines[k] <= lines[k] >> layer_pkg::PIXEL_W;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			issue_beat <= '0;
			issue_done <= 1'b0;
			rd_pend <= 1'b0;
			rd_beat_q <= '0;
			win_cnt <= '0;
		end else begin
			rd_pend <= issuing;
			rd_beat_q <= issue_beat;
			case (state)
				S_IDLE: if (job_req) begin
					state <= S_LOAD;
					issue_beat <= '0;
					issue_done <= 1'b0;
					win_cnt <= '0;
				end
				S_LOAD: begin
					if (issuing) begin
						issue_beat <= issue_beat + 1'b1;
						issue_done <= (issue_beat == last_beat);
					end
					// last beat landed in the lines
					if (rd_pend && rd_beat_q == last_beat) state <= S_EMIT;
				end
				S_EMIT: if (win_valid) begin
					win_cnt <= win_cnt + 6'd1;
					if (win_cnt == cols - 6'd3) state <= S_ACK;
				end
				default: if (!job_req) state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/row_ring_buffer.sv ====
module row_ring_buffer #(
	parameter int MAX_COLS = 32,
	localparam int BEAT_W = layer_pkg::beat_bits(MAX_COLS)
) (
	input  logic                                 clk,
	input  logic                                 wr_en,
	input  logic [1:0]                           wr_slot,
	input  logic [BEAT_W-1:0]                    wr_beat,
	input  logic [axi_read_pkg::DATA_W-1:0]      wr_data,
	input  logic [2:0][1:0]                      rd_slot,
	input  logic [BEAT_W-1:0]                    rd_beat,
	output logic [2:0][axi_read_pkg::DATA_W-1:0] rd_data
);
	localparam int DEPTH = layer_pkg::ROW_SLOTS << BEAT_W;

	// slot in the upper address bits, beat below
	logic [axi_read_pkg::DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[{wr_slot, wr_beat}] <= wr_data;
		end
		// one port per window row, same beat on all three
		for (int k = 0; k < 3; k++) begin
			rd_data[k] <= mem[{rd_slot[k], rd_beat}];
		end
	end

endmodule

// ==== verilog/row_fetch.sv ====
module row_fetch #(
	parameter int MAX_COLS = 32,
	localparam int BEAT_W = layer_pkg::beat_bits(MAX_COLS)
) (
	input  logic                            clk,
	input  logic                            reset_n,
	input  layer_pkg::layer_cfg_t           cfg,
	input  logic                            fetch_req,
	input  layer_pkg::fetch_req_t           fetch_row,
	output logic                            fetch_ack,
	output axi_read_pkg::axi_ar_t           ar,
	output logic                            ar_valid,
	input  logic                            ar_ready,
	input  axi_read_pkg::axi_r_t            r,
	input  logic                            r_valid,
	output logic                            r_ready,
	output logic                            wr_en,
	output logic [1:0]                      wr_slot,
	output logic [BEAT_W-1:0]               wr_beat,
	output logic [axi_read_pkg::DATA_W-1:0] wr_data
);
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ADDR = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_ACK = 2'd3;

	logic [1:0]            state;
	logic [BEAT_W-1:0]     beat;
	logic [6:0]            beats_sum;
	axi_read_pkg::axi_ar_t ar_q;

	assign beats_sum = {1'b0, cfg.cols} + 7'd7;
	assign ar = ar_q;
	assign ar_valid = (state == S_ADDR);
	assign r_ready = (state == S_DATA);
	assign fetch_ack = (state == S_ACK);

	// slot stays valid while the request is held
	assign wr_en = r_ready && r_valid;
	assign wr_slot = fetch_row.slot;
	assign wr_beat = beat;
	assign wr_data = r.data;

	// --------------------------------------------------
	// burst setup, taken when the request is accepted
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == S_IDLE && fetch_req) begin
			ar_q.addr <= cfg.base_addr + 32'(fetch_row.row) * 32'(cfg.row_stride);
			ar_q.len <= 8'(beats_sum >> 3) - 8'd1;
			ar_q.size <= axi_read_pkg::AR_SIZE_16B;
			ar_q.burst <= axi_read_pkg::AR_BURST_INCR;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			beat <= '0;
		end else begin
			case (state)
				S_IDLE: if (fetch_req) begin
					state <= S_ADDR;
					beat <= '0;
				end
				S_ADDR: if (ar_ready) state <= S_DATA;
				S_DATA: if (r_valid) begin
					beat <= beat + 1'b1;
					if (r.last) state <= S_ACK;
				end
				default: if (!fetch_req) state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/stream_control.sv ====
module stream_control (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  start,
	input  logic [7:0]            rows,
	output logic                  fetch_req,
	output layer_pkg::fetch_req_t fetch_row,
	input  logic                  fetch_ack,
	output logic                  job_req,
	output layer_pkg::row_job_t   job,
	input  logic                  job_ack,
	output logic                  done
);
	logic       running;
	logic [7:0] fetch_cnt;
	logic [7:0] out_row;
	logic       job_ack_q;
	logic       fetch_ok;
	logic       rows_ready;
	logic       job_ok;

	// --------------------------------------------------
	// scheduling rule
	// --------------------------------------------------

	// stay at most two rows ahead of the output row
	assign fetch_ok = running && !fetch_req && !fetch_ack && (fetch_cnt < rows)
		&& ({1'b0, fetch_cnt} <= {1'b0, out_row} + 9'd2);

	// rows up to out_row+1 in the ring, clipped at the last row
	assign rows_ready = ({1'b0, fetch_cnt} >= {1'b0, out_row} + 9'd2) || (fetch_cnt == rows);
	assign job_ok = running && !job_req && !job_ack && (out_row < rows) && rows_ready;

	assign fetch_row.row = fetch_cnt;
	assign fetch_row.slot = fetch_cnt[1:0];
	assign job.slot = out_row[1:0];
	assign job.top_pad = (out_row == 8'd0);
	assign job.bottom_pad = (out_row == rows - 8'd1);

	// --------------------------------------------------
	// both four-phase masters and done
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			running <= 1'b0;
			fetch_req <= 1'b0;
			job_req <= 1'b0;
			fetch_cnt <= '0;
			out_row <= '0;
			job_ack_q <= 1'b0;
			done <= 1'b0;
		end else begin
			job_ack_q <= job_ack;
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				fetch_cnt <= '0;
				out_row <= '0;
				fetch_req <= 1'b1;
			end else begin
				if (fetch_req && fetch_ack) begin
					fetch_req <= 1'b0;
					fetch_cnt <= fetch_cnt + 8'd1;
				end else if (fetch_ok) begin
					fetch_req <= 1'b1;
				end
				if (job_req && job_ack) begin
					job_req <= 1'b0;
					out_row <= out_row + 8'd1;
				end else if (job_ok) begin
					job_req <= 1'b1;
				end
				// final ack has just fallen
				if (running && job_ack_q && !job_ack && out_row == rows) begin
					done <= 1'b1;
					running <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== verilog/axi_read_pkg.sv ====
package axi_read_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 128;

	// 16 byte beats, incrementing bursts
	localparam logic [2:0] AR_SIZE_16B = 3'd4;
	localparam logic [1:0] AR_BURST_INCR = 2'd1;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} axi_r_t;

endpackage

// ==== verilog/layer_pkg.sv ====
package layer_pkg;

	localparam int PIXEL_W = 16;
	localparam int PIXELS_PER_BEAT = 8;
	localparam int WINDOW_PIXELS = 9;
	localparam int ROW_SLOTS = 4;

	// fp16 fields
	typedef struct packed {
		logic       sign;
		logic [4:0] exponent;
		logic [9:0] mantissa;
	} half_t;

	// one pixel word, integer before the cast and half after it
	typedef union packed {
		logic signed [PIXEL_W-1:0] int_val;
		half_t                     half;
	} pixel_t;

	// index 0 is the top left pixel, row-major
	typedef pixel_t [WINDOW_PIXELS-1:0] window_t;

	typedef struct packed {
		logic [31:0] base_addr;
		logic [15:0] row_stride;
		logic [7:0]  rows;
		logic [5:0]  cols;
		logic        cast;
	} layer_cfg_t;

	typedef struct packed {
		logic [7:0] row;
		logic [1:0] slot;
	} fetch_req_t;

	typedef struct packed {
		logic [1:0] slot;
		logic       top_pad;
		logic       bottom_pad;
	} row_job_t;

	// beat address bits needed for a row of max_cols pixels
	function automatic int beat_bits(input int max_cols);
		int beats;
		beats = (max_cols + PIXELS_PER_BEAT - 1) / PIXELS_PER_BEAT;
		return (beats > 1) ? $clog2(beats) : 1;
	endfunction

endpackage
